// File: Makefile
# Verilator flow for the boot loader

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module boot_loader_top -f boot_loader_top.f

sim:
	verilator --binary --timing --top-module tb_boot_loader -f boot_loader_top.f -o sim_boot_loader
	./obj_dir/sim_boot_loader | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: boot_loader_top.f
+incdir+include
verilog/boot_loader_pkg.sv
verilog/cfg_loader.sv
verilog/nbf_loader.sv
verilog/load_channel_mux.sv
verilog/boot_loader_top.sv
tb/tb_boot_loader.sv

// File: include/boot_loader_cfg.svh
// Boot loader configuration
`ifndef BOOT_LOADER_CFG_SVH
`define BOOT_LOADER_CFG_SVH

// Command field widths
`define BOOT_ADDR_W 40
`define BOOT_DATA_W 64

// Commands in flight per loader
`define BOOT_CREDITS 8

// Configuration register map
`define BOOT_FREEZE_ADDR   40'h00_0020_0008
`define BOOT_CORE_ID_ADDR  40'h00_0020_0010
`define BOOT_CCE_MODE_ADDR 40'h00_0020_0018
`define BOOT_INSTR_BASE    40'h00_0020_8000

// Values written at boot
`define BOOT_CORE_ID  64'h0000_0000_0000_0002
`define BOOT_CCE_MODE 64'h0000_0000_0000_0001

// Coherence engine instruction table
`define BOOT_INSTR_ELS 4
`define BOOT_INSTR_0   64'h0000_0000_1a2b_3c01
`define BOOT_INSTR_1   64'h0000_0000_2b3c_4d02
`define BOOT_INSTR_2   64'h0000_0000_3c4d_5e03
`define BOOT_INSTR_3   64'h0000_0000_4d5e_6f04

`endif

// File: tb/boot_stimulus.txt
# C addr data: expected configuration command, in issue order
# N op addr data: program record, op 0 write, 1 fence, 2 finish; E addr data: expected command
C 0000200008 0000000000000001
C 0000200010 0000000000000002
C 0000200018 0000000000000001
C 0000208000 000000001a2b3c01
C 0000208008 000000002b3c4d02
C 0000208010 000000003c4d5e03
C 0000208018 000000004d5e6f04
N 0 0080000000 a5a5000000000001
N 0 0080000008 a5a5000000000002
N 0 0080000010 a5a5000000000003
N 0 0080000018 a5a5000000000004
N 0 0080000020 a5a5000000000005
N 0 0080000028 a5a5000000000006
N 0 0080000030 a5a5000000000007
N 0 0080000038 a5a5000000000008
N 0 0080000040 a5a5000000000009
N 1 0000000000 0000000000000000
N 0 0080001000 5a5a0000000000a1
N 0 0080001008 5a5a0000000000a2
N 0 0080001010 5a5a0000000000a3
N 2 0000000000 0000000000000000
E 0080000000 a5a5000000000001
E 0080000008 a5a5000000000002
E 0080000010 a5a5000000000003
E 0080000018 a5a5000000000004
E 0080000020 a5a5000000000005
E 0080000028 a5a5000000000006
E 0080000030 a5a5000000000007
E 0080000038 a5a5000000000008
E 0080000040 a5a5000000000009
E 0080001000 5a5a0000000000a1
E 0080001008 5a5a0000000000a2
E 0080001010 5a5a0000000000a3

// File: tb/tb_boot_loader.sv
// Boot loader testbench
`timescale 1ns/1ps
`include "boot_loader_cfg.svh"

module tb_boot_loader;

   localparam int cfg_cmds_lp = 3 + `BOOT_INSTR_ELS;
   localparam int guard_lp    = 500;

   logic                       clk_i;
   logic                       reset_i;
   boot_loader_pkg::nbf_rec_s  nbf_rec_i;
   logic                       nbf_v_i;
   logic                       nbf_ready_o;
   boot_loader_pkg::load_cmd_s io_cmd_o;
   logic                       io_cmd_v_o;
   logic                       io_cmd_ready_i;
   logic                       io_resp_v_i;
   logic                       cfg_done_o;
   logic                       nbf_done_o;

   boot_loader_pkg::load_cmd_s cfg_exp_q[$];
   boot_loader_pkg::load_cmd_s nbf_exp_q[$];
   boot_loader_pkg::nbf_rec_s  rec_q[$];
   boot_loader_pkg::load_cmd_s prev_cmd;
   int   xfer_q[$];
   int   due_q[$];
   int   cycle_cnt = 0;
   int   outstanding = 0;
   int   cfg_xfers = 0;
   int   nbf_xfers = 0;
   int   error_cnt = 0;
   int   check_cnt = 0;
   int   test_cnt = 0;
   int   test_err_base = 0;
   logic ack_hold = 1'b0;
   logic fence_active = 1'b0;
   logic cfg_done_seen = 1'b0;
   logic nbf_done_seen = 1'b0;
   logic prev_v = 1'b0;
   logic prev_ready = 1'b0;

   boot_loader_top
      #(.credit_p(`BOOT_CREDITS))
      i_dut
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.nbf_rec_i(nbf_rec_i)
       ,.nbf_v_i(nbf_v_i)
       ,.nbf_ready_o(nbf_ready_o)
       ,.io_cmd_o(io_cmd_o)
       ,.io_cmd_v_o(io_cmd_v_o)
       ,.io_cmd_ready_i(io_cmd_ready_i)
       ,.io_resp_v_i(io_resp_v_i)
       ,.cfg_done_o(cfg_done_o)
       ,.nbf_done_o(nbf_done_o)
       );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
      cycle_cnt <= cycle_cnt + 1;

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      check_cnt++;
      if (expected !== actual)
      begin
         error_cnt++;
         $display("Error at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic note_failure(input string msg);
      error_cnt++;
      $display("Failure at %0t ns: %s", $time, msg);
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      $display("Test %0d %s done, %0d errors", test_cnt, name, error_cnt - test_err_base);
      test_err_base = error_cnt;
   endtask

   task automatic check_quiet_outputs();
      check_value("io_cmd_v_o", 128'(0), 128'(io_cmd_v_o));
      check_value("nbf_ready_o", 128'(0), 128'(nbf_ready_o));
      check_value("cfg_done_o", 128'(0), 128'(cfg_done_o));
      check_value("nbf_done_o", 128'(0), 128'(nbf_done_o));
   endtask

   task automatic read_stimulus();
      int                         fd;
      int                         code;
      string                      line;
      logic [1:0]                 op_v;
      logic [`BOOT_ADDR_W-1:0]    addr_v;
      logic [`BOOT_DATA_W-1:0]    data_v;
      boot_loader_pkg::load_cmd_s exp_cmd;
      boot_loader_pkg::nbf_rec_s  rec_item;
      fd = $fopen("tb/boot_stimulus.txt", "r");
      if (fd == 0)
         note_failure("cannot open tb/boot_stimulus.txt");
      else
      begin
         while (!$feof(fd))
         begin
            code = $fgets(line, fd);
            // Lines without a known leading letter are comments
            if (code > 0 && line.len() > 2)
            begin
               exp_cmd.op = boot_loader_pkg::CMD_WRITE;
               case (line.getc(0))
                  "C", "E":
                  begin
                     code = $sscanf(line.substr(2, line.len() - 1), "%h %h", addr_v, data_v);
                     exp_cmd.addr = addr_v;
                     exp_cmd.data = data_v;
                     if (line.getc(0) == "C")
                        cfg_exp_q.push_back(exp_cmd);
                     else
                        nbf_exp_q.push_back(exp_cmd);
                  end
                  "N":
                  begin
                     code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h",
                                    op_v, addr_v, data_v);
                     rec_item.op   = boot_loader_pkg::nbf_op_e'(op_v);
                     rec_item.addr = addr_v;
                     rec_item.data = data_v;
                     rec_q.push_back(rec_item);
                  end
                  default:
                     code = 0;
               endcase
            end
         end
         $fclose(fd);
      end
      check_value("C lines in stimulus", 128'(cfg_cmds_lp), 128'(cfg_exp_q.size()));
   endtask

   // Record source with one record per handshake
   task automatic drive_records();
      int guard;
      foreach (rec_q[k])
      begin
         @(posedge clk_i);
         #1;
         nbf_rec_i = rec_q[k];
         nbf_v_i   = 1'b1;
         guard     = 0;
         @(negedge clk_i);
         while (!nbf_ready_o)
         begin
            guard++;
            if (guard > guard_lp)
               stop_on_timeout("nbf_ready_o");
            @(negedge clk_i);
         end
      end
      @(posedge clk_i);
      #1;
      nbf_v_i = 1'b0;
   endtask

   task automatic log_transfer();
      boot_loader_pkg::load_cmd_s exp_cmd;
      if (nbf_done_seen)
         note_failure("command transferred after nbf_done_o rose");
      else if (!cfg_done_o)
      begin
         if (cfg_exp_q.size() == 0)
            note_failure("extra command transferred before cfg_done_o");
         else
         begin
            exp_cmd = cfg_exp_q.pop_front();
            check_value("io_cmd_o (config)", 128'(exp_cmd), 128'(io_cmd_o));
         end
         cfg_xfers++;
      end
      else
      begin
         // Every earlier command must be acknowledged past a fence
         if (fence_active)
            check_value("acks pending after fence", 128'(0), 128'(outstanding));
         fence_active = 1'b0;
         if (nbf_exp_q.size() == 0)
            note_failure("program command beyond the expected list");
         else
         begin
            exp_cmd = nbf_exp_q.pop_front();
            check_value("io_cmd_o (program)", 128'(exp_cmd), 128'(io_cmd_o));
         end
         nbf_xfers++;
      end
      outstanding++;
      xfer_q.push_back(cycle_cnt + 1);
   endtask

   // Outside end of the channel with random ready and in-order delayed acks
   initial
   begin
      void'($urandom(65));
      io_cmd_ready_i = 1'b0;
      io_resp_v_i    = 1'b0;
      forever
      begin
         @(posedge clk_i);
         #1;
         while (xfer_q.size() > 0)
            due_q.push_back(xfer_q.pop_front() + int'($urandom % 6));
         io_cmd_ready_i = ($urandom % 4) != 0;
         io_resp_v_i    = 1'b0;
         if (!ack_hold && due_q.size() > 0 && due_q[0] <= cycle_cnt)
         begin
            io_resp_v_i = 1'b1;
            void'(due_q.pop_front());
         end
      end
   end

   // Channel monitor sampled mid-cycle when inputs and outputs are settled
   always @(negedge clk_i)
   begin
      if (!reset_i)
      begin
         if (prev_v && !prev_ready)
         begin
            check_value("io_cmd_v_o while stalled", 128'(1), 128'(io_cmd_v_o));
            check_value("io_cmd_o while stalled", 128'(prev_cmd), 128'(io_cmd_o));
         end
         if (cfg_done_o && !cfg_done_seen)
         begin
            cfg_done_seen = 1'b1;
            check_value("acks pending at cfg_done_o", 128'(0), 128'(outstanding));
            check_value("config transfers at cfg_done_o", 128'(cfg_cmds_lp), 128'(cfg_xfers));
         end
         else if (!cfg_done_o && cfg_done_seen)
            note_failure("cfg_done_o fell without reset");
         if (nbf_done_o && !nbf_done_seen)
         begin
            nbf_done_seen = 1'b1;
            check_value("acks pending at nbf_done_o", 128'(0), 128'(outstanding));
         end
         else if (!nbf_done_o && nbf_done_seen)
            note_failure("nbf_done_o fell without reset");
         if (nbf_done_seen && nbf_ready_o)
            note_failure("nbf_ready_o high after the finish record");
         if (nbf_v_i && nbf_ready_o && nbf_rec_i.op == boot_loader_pkg::NBF_FENCE)
            fence_active = 1'b1;
         if (io_cmd_v_o && io_cmd_ready_i)
            log_transfer();
         if (io_resp_v_i && outstanding > 0)
            outstanding--;
         if (outstanding > `BOOT_CREDITS)
            note_failure("more commands in flight than the credit limit");
      end
      prev_v     = io_cmd_v_o;
      prev_ready = io_cmd_ready_i;
      prev_cmd   = io_cmd_o;
   end

   initial
   begin
      int guard;
      reset_i   = 1'b1;
      nbf_v_i   = 1'b0;
      nbf_rec_i = '0;
      read_stimulus();

      repeat (15)
      begin
         @(negedge clk_i);
         check_quiet_outputs();
      end
      @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      @(negedge clk_i);
      check_quiet_outputs();
      @(negedge clk_i);
      check_value("io_cmd_v_o after reset", 128'(1), 128'(io_cmd_v_o));
      end_test("reset outputs");
      fork
         drive_records();
      join_none

      guard = 0;
      while (cfg_xfers < cfg_cmds_lp)
      begin
         @(negedge clk_i);
         guard++;
         if (guard > guard_lp)
            stop_on_timeout("configuration transfers");
      end
      end_test("configuration commands");

      guard = 0;
      while (!cfg_done_o)
      begin
         @(negedge clk_i);
         guard++;
         if (guard > guard_lp)
            stop_on_timeout("cfg_done_o");
      end
      // Hold acks from here so the program loader hits its credit limit
      ack_hold = 1'b1;
      end_test("configuration done");

      guard = 0;
      while (nbf_xfers < `BOOT_CREDITS)
      begin
         @(negedge clk_i);
         guard++;
         if (guard > guard_lp)
            stop_on_timeout("program transfers up to the credit limit");
      end
      repeat (20)
      begin
         @(negedge clk_i);
         check_value("transfers with acks held", 128'(`BOOT_CREDITS), 128'(nbf_xfers));
      end
      ack_hold = 1'b0;
      guard    = 0;
      while (nbf_xfers <= `BOOT_CREDITS)
      begin
         @(negedge clk_i);
         guard++;
         if (guard > guard_lp)
            stop_on_timeout("issue to resume after acks");
      end
      end_test("credit limit");

      guard = 0;
      while (nbf_exp_q.size() > 0)
      begin
         @(negedge clk_i);
         guard++;
         if (guard > guard_lp)
            stop_on_timeout("program commands");
      end
      end_test("program commands and fence");

      guard = 0;
      while (!nbf_done_o)
      begin
         @(negedge clk_i);
         guard++;
         if (guard > guard_lp)
            stop_on_timeout("nbf_done_o");
      end
      // A write record offered after finish must stay unaccepted
      @(posedge clk_i);
      #1;
      nbf_rec_i = rec_q[0];
      nbf_v_i   = 1'b1;
      repeat (20) @(negedge clk_i);
      check_value("nbf_ready_o after finish", 128'(0), 128'(nbf_ready_o));
      end_test("finish");

      $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: verilog/boot_loader_pkg.sv
// Boot loader types
`include "boot_loader_cfg.svh"

package boot_loader_pkg;

   // Both loaders only issue write commands
   typedef enum logic
   {
      CMD_READ   = 1'b0
      ,CMD_WRITE = 1'b1
   } cmd_op_e;

   typedef struct packed
   {
      cmd_op_e                 op;
      logic [`BOOT_ADDR_W-1:0] addr;
      logic [`BOOT_DATA_W-1:0] data;
   } load_cmd_s;

   // Program record opcode
   typedef enum logic [1:0]
   {
      NBF_WRITE   = 2'b00
      ,NBF_FENCE  = 2'b01
      ,NBF_FINISH = 2'b10
   } nbf_op_e;

   typedef struct packed
   {
      nbf_op_e                 op;
      logic [`BOOT_ADDR_W-1:0] addr;
      logic [`BOOT_DATA_W-1:0] data;
   } nbf_rec_s;

endpackage

// File: verilog/boot_loader_top.sv
// Boot loader top level
`timescale 1ns/1ps
`include "boot_loader_cfg.svh"

module boot_loader_top
   #(parameter int credit_p = `BOOT_CREDITS)
   (input  logic                       clk_i
    ,input logic                       reset_i

    ,input  boot_loader_pkg::nbf_rec_s nbf_rec_i
    ,input  logic                      nbf_v_i
    ,output logic                      nbf_ready_o

    ,output boot_loader_pkg::load_cmd_s io_cmd_o
    ,output logic                      io_cmd_v_o
    ,input  logic                      io_cmd_ready_i

    ,input  logic                      io_resp_v_i

    ,output logic                      cfg_done_o
    ,output logic                      nbf_done_o
    );

   boot_loader_pkg::load_cmd_s cfg_cmd_lo;
   logic                       cfg_cmd_v_lo;
   logic                       cfg_cmd_ready_li;
   logic                       cfg_ack_li;

   boot_loader_pkg::load_cmd_s nbf_cmd_lo;
   logic                       nbf_cmd_v_lo;
   logic                       nbf_cmd_ready_li;
   logic                       nbf_ack_li;

   cfg_loader
      #(.credit_p(credit_p))
      cfg_loader
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.cmd_o(cfg_cmd_lo)
       ,.cmd_v_o(cfg_cmd_v_lo)
       ,.cmd_ready_i(cfg_cmd_ready_li)
       ,.ack_i(cfg_ack_li)
       ,.done_o(cfg_done_o)
       );

   nbf_loader
      #(.credit_p(credit_p))
      nbf_loader
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.rec_i(nbf_rec_i)
       ,.rec_v_i(nbf_v_i)
       ,.rec_ready_o(nbf_ready_o)
       ,.cmd_o(nbf_cmd_lo)
       ,.cmd_v_o(nbf_cmd_v_lo)
       ,.cmd_ready_i(nbf_cmd_ready_li)
       ,.ack_i(nbf_ack_li)
       ,.done_o(nbf_done_o)
       );

   // Configuration owns the channel until it is done
   load_channel_mux
      channel_mux
      (.cfg_done_i(cfg_done_o)
       ,.cfg_cmd_i(cfg_cmd_lo)
       ,.cfg_cmd_v_i(cfg_cmd_v_lo)
       ,.cfg_cmd_ready_o(cfg_cmd_ready_li)
       ,.cfg_ack_o(cfg_ack_li)
       ,.nbf_cmd_i(nbf_cmd_lo)
       ,.nbf_cmd_v_i(nbf_cmd_v_lo)
       ,.nbf_cmd_ready_o(nbf_cmd_ready_li)
       ,.nbf_ack_o(nbf_ack_li)
       ,.io_cmd_o(io_cmd_o)
       ,.io_cmd_v_o(io_cmd_v_o)
       ,.io_cmd_ready_i(io_cmd_ready_i)
       ,.io_resp_v_i(io_resp_v_i)
       );

endmodule

// File: verilog/cfg_loader.sv
// Configuration loader
`timescale 1ns/1ps
`include "boot_loader_cfg.svh"

module cfg_loader
   #(parameter int credit_p = `BOOT_CREDITS)
   (input  logic                       clk_i
    ,input logic                       reset_i

    ,output boot_loader_pkg::load_cmd_s cmd_o
    ,output logic                      cmd_v_o
    ,input  logic                      cmd_ready_i

    ,input  logic                      ack_i

    ,output logic                      done_o
    );

   // Freeze, core id and mode, then the instruction table
   localparam int num_steps_lp = 3 + `BOOT_INSTR_ELS;
   localparam int step_w_lp    = $clog2(num_steps_lp + 1);
   localparam int credit_w_lp  = $clog2(credit_p + 1);

   localparam logic [step_w_lp-1:0]   last_step_lp  = step_w_lp'(num_steps_lp);
   localparam logic [credit_w_lp-1:0] credit_max_lp = credit_w_lp'(credit_p);

   logic                   run_r;
   logic                   done_r;
   logic [step_w_lp-1:0]   step_r;
   logic [step_w_lp-1:0]   instr_idx;
   logic [credit_w_lp-1:0] credits_r;
   logic [credit_w_lp-1:0] credits_n;
   logic                   cmd_fire;

   assign cmd_v_o   = run_r & (step_r != last_step_lp) & (credits_r != credit_max_lp);
   assign cmd_fire  = cmd_v_o & cmd_ready_i;
   assign done_o    = done_r;
   assign instr_idx = step_r - step_w_lp'(3);

   always_comb
   begin
      cmd_o.op = boot_loader_pkg::CMD_WRITE;
      case (step_r)
         step_w_lp'(0):
         begin
            cmd_o.addr = `BOOT_FREEZE_ADDR;
            cmd_o.data = `BOOT_DATA_W'(1);
         end
         step_w_lp'(1):
         begin
            cmd_o.addr = `BOOT_CORE_ID_ADDR;
            cmd_o.data = `BOOT_CORE_ID;
         end
         step_w_lp'(2):
         begin
            cmd_o.addr = `BOOT_CCE_MODE_ADDR;
            cmd_o.data = `BOOT_CCE_MODE;
         end
         default:
         begin
            // Table entries are 8 bytes apart
            cmd_o.addr = `BOOT_INSTR_BASE + `BOOT_ADDR_W'({instr_idx, 3'b000});
            case (instr_idx)
               step_w_lp'(0): cmd_o.data = `BOOT_INSTR_0;
               step_w_lp'(1): cmd_o.data = `BOOT_INSTR_1;
               step_w_lp'(2): cmd_o.data = `BOOT_INSTR_2;
               step_w_lp'(3): cmd_o.data = `BOOT_INSTR_3;
               default:       cmd_o.data = '0;
            endcase
         end
      endcase
   end

   always_comb
   begin
      credits_n = credits_r;
      if (cmd_fire & ~ack_i)
         credits_n = credits_r + 1'b1;
      else if (ack_i & ~cmd_fire)
         credits_n = credits_r - 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         run_r     <= 1'b0;
         done_r    <= 1'b0;
         step_r    <= '0;
         credits_r <= '0;
      end
      else
      begin
         run_r     <= 1'b1;
         credits_r <= credits_n;
         if (cmd_fire)
            step_r <= step_r + 1'b1;
         // Done in the cycle after the last acknowledge
         if ((step_r == last_step_lp) && (credits_n == '0))
            done_r <= 1'b1;
      end
   end

endmodule

// File: verilog/load_channel_mux.sv
// Loader command channel mux
`timescale 1ns/1ps

module load_channel_mux
   (input  logic                       cfg_done_i

    ,input  boot_loader_pkg::load_cmd_s cfg_cmd_i
    ,input  logic                      cfg_cmd_v_i
    ,output logic                      cfg_cmd_ready_o
    ,output logic                      cfg_ack_o

    ,input  boot_loader_pkg::load_cmd_s nbf_cmd_i
    ,input  logic                      nbf_cmd_v_i
    ,output logic                      nbf_cmd_ready_o
    ,output logic                      nbf_ack_o

    ,output boot_loader_pkg::load_cmd_s io_cmd_o
    ,output logic                      io_cmd_v_o
    ,input  logic                      io_cmd_ready_i

    ,input  logic                      io_resp_v_i
    );

   // The loaders take turns, so the selection is just cfg_done
   always_comb
   begin
      cfg_cmd_ready_o = 1'b0;
      cfg_ack_o       = 1'b0;
      nbf_cmd_ready_o = 1'b0;
      nbf_ack_o       = 1'b0;
      if (~cfg_done_i)
      begin
         io_cmd_o        = cfg_cmd_i;
         io_cmd_v_o      = cfg_cmd_v_i;
         cfg_cmd_ready_o = io_cmd_ready_i;
         cfg_ack_o       = io_resp_v_i;
      end
      else
      begin
         io_cmd_o        = nbf_cmd_i;
         io_cmd_v_o      = nbf_cmd_v_i;
         nbf_cmd_ready_o = io_cmd_ready_i;
         nbf_ack_o       = io_resp_v_i;
      end
   end

endmodule

// File: verilog/nbf_loader.sv
// Program record loader
`timescale 1ns/1ps
`include "boot_loader_cfg.svh"

module nbf_loader
   #(parameter int credit_p = `BOOT_CREDITS)
   (input  logic                       clk_i
    ,input logic                       reset_i

    ,input  boot_loader_pkg::nbf_rec_s rec_i
    ,input  logic                      rec_v_i
    ,output logic                      rec_ready_o

    ,output boot_loader_pkg::load_cmd_s cmd_o
    ,output logic                      cmd_v_o
    ,input  logic                      cmd_ready_i

    ,input  logic                      ack_i

    ,output logic                      done_o
    );

   localparam int credit_w_lp = $clog2(credit_p + 1);
   localparam logic [credit_w_lp-1:0] credit_max_lp = credit_w_lp'(credit_p);

   typedef enum logic [1:0]
   {
      S_IDLE
      ,S_ISSUE
      ,S_DRAIN
      ,S_FINISHED
   } state_e;

   state_e                    state_r;
   state_e                    state_n;
   boot_loader_pkg::nbf_rec_s rec_r;
   logic                      ready_r;
   logic [credit_w_lp-1:0]    credits_r;
   logic [credit_w_lp-1:0]    credits_n;
   logic                      rec_fire;
   logic                      cmd_fire;

   assign rec_ready_o = ready_r;
   assign rec_fire    = rec_v_i & ready_r;
   assign cmd_v_o     = (state_r == S_ISSUE) & (credits_r != credit_max_lp);
   assign cmd_fire    = cmd_v_o & cmd_ready_i;
   assign done_o      = (state_r == S_FINISHED);

   assign cmd_o = '{op: boot_loader_pkg::CMD_WRITE, addr: rec_r.addr, data: rec_r.data};

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         S_IDLE:
            if (rec_fire)
               state_n = (rec_i.op == boot_loader_pkg::NBF_WRITE) ? S_ISSUE : S_DRAIN;
         S_ISSUE:
            if (cmd_fire)
               state_n = S_IDLE;
         // Unknown opcodes drain like a fence
         S_DRAIN:
            if (credits_r == '0)
               state_n = (rec_r.op == boot_loader_pkg::NBF_FINISH) ? S_FINISHED : S_IDLE;
         default:
            state_n = S_FINISHED;
      endcase
   end

   always_comb
   begin
      credits_n = credits_r;
      if (cmd_fire & ~ack_i)
         credits_n = credits_r + 1'b1;
      else if (ack_i & ~cmd_fire)
         credits_n = credits_r - 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r   <= S_IDLE;
         ready_r   <= 1'b0;
         credits_r <= '0;
      end
      else
      begin
         state_r   <= state_n;
         ready_r   <= (state_n == S_IDLE);
         credits_r <= credits_n;
      end
   end

   // Holding register for the accepted record
   always_ff @(posedge clk_i)
   begin
      if (rec_fire)
         rec_r <= rec_i;
   end

endmodule
